// ==== common/timer_pkg.sv ====
package timer_pkg;

    // prescaler divides the clock by value + 1
    localparam int PRESC_W = 8;

    // counter width, also the width of the register data bus
    localparam int TIMER_W = 16;

    // address layout is {channel, field}
    localparam int FIELD_W = 3;   // low address bits select the register
    localparam int ADDR_W  = 8;   // upper bits give the channel index

    // register map inside one channel window
    typedef enum logic [FIELD_W-1:0] {
        F_CTRL  = 3'd0,   // bit0 go level, bit1 relatch pulse on write
        F_PRESC = 3'd1,   // prescaler setting
        F_TOP   = 3'd2,   // wrap value of the counter
        F_CMP   = 3'd3,   // compare value, pwm high while count <= cmp
        F_COUNT = 3'd4,   // live counter, read only
        F_FLAGS = 3'd5,   // bit0 top, bit1 cmp, write one to clear
        F_MASK  = 3'd6    // irq enables, same layout as F_FLAGS
    } reg_field_e;

    // config handed from the register bank to a channel
    // sampled by the channel only on start or relatch
    typedef struct packed {
        logic [PRESC_W-1:0] prescaler;   // clocks per count minus one
        logic [TIMER_W-1:0] top;         // last count before wrap
        logic [TIMER_W-1:0] cmp;         // compare point
    } ch_cfg_t;

    // live status from a channel
    typedef struct packed {
        logic               cmp_match;   // count == cmp while running
        logic               top_match;   // count == top while running
        logic               pwm;         // count <= cmp while running
        logic [TIMER_W-1:0] counter;     // raw counter, holds when stopped
    } ch_stat_t;

    // flag and mask bit positions
    localparam int FLAG_TOP = 0;
    localparam int FLAG_CMP = 1;

endpackage

// ==== timer/timer.sv ====
module timer (
    input  logic                clk,
    input  logic                rst_n,
    input  timer_pkg::ch_cfg_t  cfg,       // config from the register bank
    input  logic                go,        // run level
    input  logic                relatch,   // one cycle pulse, take new cfg on the fly
    output timer_pkg::ch_stat_t stat       // match, pwm and counter
);

    logic                          run_q;       // run latch, the only real state
    timer_pkg::ch_cfg_t            cfg_q;       // config in use
    logic [timer_pkg::PRESC_W-1:0] presc_cnt;   // clocks within one count step
    logic [timer_pkg::TIMER_W-1:0] count;       // main counter
    logic                          start;
    logic                          load;
    logic                          step;

    // go seen high while stopped
    assign start = go && !run_q;

    // take a fresh copy of the config on start, or on relatch while running
    assign load = start || (run_q && go && relatch);

    // prescaler has run out, counter moves on this edge
    assign step = (presc_cnt == cfg_q.prescaler);

    // latched settings
    always_ff @(posedge clk) begin
        if (load) begin
            cfg_q <= cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q     <= 1'b0;
            presc_cnt <= '0;
            count     <= '0;
        end else if (start) begin
            // restart from zero with the new settings
            run_q     <= 1'b1;
            presc_cnt <= '0;
            count     <= '0;
        end else if (run_q) begin
            if (!go) begin
                run_q <= 1'b0;   // stop, counter keeps its value
            end else if (!relatch) begin
                // relatch cycle stalls counting, otherwise advance
                if (step) begin
                    presc_cnt <= '0;
                    if (count == cfg_q.top) begin
                        count <= '0;   // wrap
                    end else begin
                        count <= count + 1'b1;
                    end
                end else begin
                    presc_cnt <= presc_cnt + 1'b1;
                end
            end
        end
    end

    // outputs decoded from the counter, held low while stopped
    assign stat = '{
        cmp_match: run_q && (count == cfg_q.cmp),
        top_match: run_q && (count == cfg_q.top),
        pwm:       run_q && (count <= cfg_q.cmp),
        counter:   count
    };

endmodule

// ==== timer/timer_regs.sv ====
module timer_regs #(
    parameter int NUM_CH = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,            // single cycle write strobe
    input  logic                          rd_en,            // single cycle read strobe
    input  logic [timer_pkg::ADDR_W-1:0]  addr,             // {channel, field}
    input  logic [timer_pkg::TIMER_W-1:0] wdata,
    input  timer_pkg::ch_stat_t           stat [NUM_CH],    // live counters
    input  logic [1:0]                    flags [NUM_CH],   // sticky event flags
    output logic [timer_pkg::TIMER_W-1:0] rdata,            // valid the cycle after rd_en
    output timer_pkg::ch_cfg_t            cfg [NUM_CH],
    output logic [NUM_CH-1:0]             go,
    output logic [NUM_CH-1:0]             relatch,          // one cycle after the ctrl write
    output logic [1:0]                    flag_clr [NUM_CH],
    output logic [1:0]                    mask [NUM_CH]
);

    localparam int CH_W = timer_pkg::ADDR_W - timer_pkg::FIELD_W;   // channel index bits
    localparam int PAD_P = timer_pkg::TIMER_W - timer_pkg::PRESC_W;  // zero fill for presc
    localparam int PAD_F = timer_pkg::TIMER_W - 2;                   // zero fill for flags

    logic [CH_W-1:0]                ch_idx;
    timer_pkg::reg_field_e          field;
    logic [NUM_CH-1:0]              ch_sel;   // one hot, all zero for unused channels
    logic [NUM_CH-1:0]              wr_ch;    // write aimed at channel i
    logic [timer_pkg::TIMER_W-1:0]  rd_val;

    // address split
    assign ch_idx = addr[timer_pkg::ADDR_W-1:timer_pkg::FIELD_W];
    assign field  = timer_pkg::reg_field_e'(addr[timer_pkg::FIELD_W-1:0]);

    // channel decode
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            ch_sel[i] = (int'(ch_idx) == i);
            wr_ch[i]  = wr_en && ch_sel[i];
        end
    end

    // write one to clear, passed straight to the flag block on the write cycle
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            if (wr_ch[i] && (field == timer_pkg::F_FLAGS)) begin
                flag_clr[i] = wdata[1:0];
            end else begin
                flag_clr[i] = 2'b00;
            end
        end
    end

    // per channel settings
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            go      <= '0;
            relatch <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                cfg[i]  <= '0;
                mask[i] <= 2'b00;
            end
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                // relatch fires the cycle after, so the channel sees the updated cfg
                relatch[i] <= wr_ch[i] && (field == timer_pkg::F_CTRL) && wdata[1];
                if (wr_ch[i]) begin
                    case (field)
                        timer_pkg::F_CTRL:  go[i]            <= wdata[0];
                        timer_pkg::F_PRESC: cfg[i].prescaler <= wdata[timer_pkg::PRESC_W-1:0];
                        timer_pkg::F_TOP:   cfg[i].top       <= wdata;
                        timer_pkg::F_CMP:   cfg[i].cmp       <= wdata;
                        timer_pkg::F_MASK:  mask[i]          <= wdata[1:0];
                        default: ;   // count and flags not stored here, field 7 unused
                    endcase
                end
            end
        end
    end

    // read mux
    always_comb begin
        rd_val = '0;   // unused address reads zero
        for (int i = 0; i < NUM_CH; i++) begin
            if (ch_sel[i]) begin
                case (field)
                    timer_pkg::F_CTRL:  rd_val = {{(timer_pkg::TIMER_W-1){1'b0}}, go[i]};
                    timer_pkg::F_PRESC: rd_val = {{PAD_P{1'b0}}, cfg[i].prescaler};
                    timer_pkg::F_TOP:   rd_val = cfg[i].top;
                    timer_pkg::F_CMP:   rd_val = cfg[i].cmp;
                    timer_pkg::F_COUNT: rd_val = stat[i].counter;   // live value
                    timer_pkg::F_FLAGS: rd_val = {{PAD_F{1'b0}}, flags[i]};
                    timer_pkg::F_MASK:  rd_val = {{PAD_F{1'b0}}, mask[i]};
                    default:            rd_val = '0;
                endcase
            end
        end
    end

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= rd_val;
        end
    end

endmodule

// ==== verilog/timer_irq.sv ====
module timer_irq #(
    parameter int NUM_CH = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  timer_pkg::ch_stat_t stat [NUM_CH],       // match pulses from the channels
    input  logic [1:0]          flag_clr [NUM_CH],   // write one to clear
    input  logic [1:0]          mask [NUM_CH],       // irq enables
    output logic [1:0]          flags [NUM_CH],      // sticky flags, bit0 top, bit1 cmp
    output logic                irq
);

    logic [1:0]        set [NUM_CH];   // events seen this cycle
    logic [NUM_CH-1:0] pend;           // masked flags per channel

    // gather events in flag layout
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            set[i][timer_pkg::FLAG_TOP] = stat[i].top_match;
            set[i][timer_pkg::FLAG_CMP] = stat[i].cmp_match;
        end
    end

    // matches can last only one clock at prescaler 0, so hold them until cleared
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                flags[i] <= 2'b00;
            end
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                flags[i] <= (flags[i] & ~flag_clr[i]) | set[i];   // set beats clear
            end
        end
    end

    // any enabled flag per channel
    always_comb begin
        for (int i = 0; i < NUM_CH; i++) begin
            pend[i] = |(flags[i] & mask[i]);
        end
    end

    // single registered irq line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= |pend;
        end
    end

endmodule

// ==== verilog/pwm_timer_top.sv ====
module pwm_timer_top #(
    parameter int NUM_CH = 2
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  logic                          rd_en,
    input  logic [timer_pkg::ADDR_W-1:0]  addr,
    input  logic [timer_pkg::TIMER_W-1:0] wdata,
    output logic [timer_pkg::TIMER_W-1:0] rdata,
    output logic [NUM_CH-1:0]             pwm,     // one pwm line per channel
    output logic                          irq      // masked event interrupt
);

    timer_pkg::ch_cfg_t  cfg [NUM_CH];        // bank to channels
    timer_pkg::ch_stat_t stat [NUM_CH];       // channels to bank, flags and pins
    logic [NUM_CH-1:0]   go;
    logic [NUM_CH-1:0]   relatch;
    logic [1:0]          flag_clr [NUM_CH];
    logic [1:0]          mask [NUM_CH];
    logic [1:0]          flags [NUM_CH];

    // register bank
    timer_regs #(
        .NUM_CH (NUM_CH)
    ) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wdata    (wdata),
        .stat     (stat),
        .flags    (flags),
        .rdata    (rdata),
        .cfg      (cfg),
        .go       (go),
        .relatch  (relatch),
        .flag_clr (flag_clr),
        .mask     (mask)
    );

    // one counter per channel
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        timer u_timer (
            .clk     (clk),
            .rst_n   (rst_n),
            .cfg     (cfg[i]),
            .go      (go[i]),
            .relatch (relatch[i]),
            .stat    (stat[i])
        );

        assign pwm[i] = stat[i].pwm;   // pin output
    end

    // sticky flags and irq
    timer_irq #(
        .NUM_CH (NUM_CH)
    ) u_irq (
        .clk      (clk),
        .rst_n    (rst_n),
        .stat     (stat),
        .flag_clr (flag_clr),
        .mask     (mask),
        .flags    (flags),
        .irq      (irq)
    );

endmodule

// ==== bench/tb_pwm_timer_table.svh ====
`ifndef TB_PWM_TIMER_TABLE_SVH
`define TB_PWM_TIMER_TABLE_SVH

localparam int NUM_ROWS = 8;

// one table entry
typedef struct packed {
    logic [7:0]  ch;        // channel under test
    logic [7:0]  presc;     // prescaler setting
    logic [15:0] top;       // wrap value
    logic [15:0] cmp;       // compare value
    logic        relatch;   // 1 = new top/cmp taken on the fly, go stays high
    logic [31:0] period;    // expected clocks between pwm rising edges
    logic [31:0] high;      // expected clocks with pwm high
} row_t;

// period = (top+1)*(presc+1), high = (cmp+1)*(presc+1)
// relatch rows keep the prescaler of the row before and never lower top,
// so the counter can't run past the new top during the switch
function automatic row_t row_at(input int r);
    row_t row;
    row = '0;
    case (r)
        //        ch     presc  top     cmp     rl    period  high
        0: row = '{8'd0, 8'd0, 16'd9,  16'd3,  1'b0, 32'd10, 32'd4};    // 10*1, 4*1
        1: row = '{8'd0, 8'd0, 16'd15, 16'd7,  1'b1, 32'd16, 32'd8};    // 16*1, 8*1
        2: row = '{8'd1, 8'd2, 16'd7,  16'd2,  1'b0, 32'd24, 32'd9};    // 8*3, 3*3
        3: row = '{8'd1, 8'd2, 16'd11, 16'd8,  1'b1, 32'd36, 32'd27};   // 12*3, 9*3
        4: row = '{8'd0, 8'd3, 16'd4,  16'd0,  1'b0, 32'd20, 32'd4};    // 5*4, 1*4
        5: row = '{8'd0, 8'd3, 16'd6,  16'd5,  1'b1, 32'd28, 32'd24};   // 7*4, 6*4
        6: row = '{8'd1, 8'd1, 16'd19, 16'd10, 1'b0, 32'd40, 32'd22};   // 20*2, 11*2
        7: row = '{8'd1, 8'd1, 16'd25, 16'd0,  1'b1, 32'd52, 32'd2};    // 26*2, 1*2
        default: row = '0;
    endcase
    return row;
endfunction

`endif

// ==== bench/tb_pwm_timer.sv ====
module tb_pwm_timer;

    localparam int NUM_CH     = 2;
    localparam int WAIT_LIMIT = 5000;   // clocks allowed for any single wait

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    logic        rd_en;
    logic [7:0]  addr;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic [1:0]  pwm;
    logic        irq;

    `include "tb_pwm_timer_table.svh"

    pwm_timer_top #(
        .NUM_CH (NUM_CH)
    ) u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (wr_en),
        .rd_en (rd_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .pwm   (pwm),
        .irq   (irq)
    );

    always #20 clk = ~clk;   // 40 unit period

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTS FAILED");
        $fatal(1, "wait limit reached");
    endtask

    // address is {channel, field}
    function automatic logic [7:0] reg_addr(input int ch, input int field);
        return 8'((ch << timer_pkg::FIELD_W) + field);
    endfunction

    // all bus tasks start and end on a falling edge
    task automatic bus_write(input int ch, input int field, input logic [15:0] data);
        addr  = reg_addr(ch, field);
        wdata = data;
        wr_en = 1'b1;
        @(negedge clk);   // taken at the rising edge in between
        wr_en = 1'b0;
    endtask

    task automatic bus_read(input int ch, input int field, output logic [15:0] data);
        addr  = reg_addr(ch, field);
        rd_en = 1'b1;
        @(negedge clk);
        rd_en = 1'b0;
        data  = rdata;   // registered on the rising edge, stable here
    endtask

    task automatic wait_pwm(input int ch, input logic level);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            if (pwm[ch] === level) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!seen) report_timeout($sformatf("pwm[%0d] to reach %0b", ch, level));
    endtask

    task automatic wait_irq(input logic level);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            if (irq === level) begin
                seen = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!seen) report_timeout($sformatf("irq to reach %0b", level));
    endtask

    // counts from the current pwm rising edge up to the next one
    task automatic measure_period(input int ch, output int period, output int high);
        logic last;
        bit   done;
        period = 0;
        high   = 0;
        done   = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !done; n++) begin
            if (pwm[ch]) high++;
            period++;
            last = pwm[ch];
            @(negedge clk);
            if (pwm[ch] && !last) done = 1'b1;   // next rising edge
        end
        if (!done) report_timeout($sformatf("next pwm[%0d] rising edge", ch));
    endtask

    // distinct per channel values for the readback test
    function automatic logic [15:0] cfg_pattern(input int ch, input int field);
        case (field)
            timer_pkg::F_PRESC: return 16'h005a + 16'(ch * 16'h0011);
            timer_pkg::F_TOP:   return 16'h1234 + 16'(ch * 16'h1111);
            timer_pkg::F_CMP:   return 16'h0bcd + 16'(ch * 16'h2222);
            default:            return 16'(ch + 1);   // mask, one bit per channel
        endcase
    endfunction

    initial begin
        logic [15:0] data;
        logic [15:0] count_a;
        row_t        row;
        int          ch;
        int          period;
        int          high;
        clk   = 1'b0;
        rst_n = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset state
        check("irq", irq, 0);
        check("pwm", pwm, 0);
        for (int c = 0; c < NUM_CH; c++) begin
            for (int f = 0; f < 8; f++) begin
                bus_read(c, f, data);
                check($sformatf("rdata ch%0d field%0d", c, f), data, 0);
            end
        end

        // readback, channel 1 written after channel 0 must not disturb it
        for (int c = 0; c < NUM_CH; c++) begin
            for (int f = timer_pkg::F_PRESC; f <= timer_pkg::F_CMP; f++) begin
                bus_write(c, f, cfg_pattern(c, f));
            end
            bus_write(c, timer_pkg::F_MASK, cfg_pattern(c, timer_pkg::F_MASK));
        end
        for (int c = 0; c < NUM_CH; c++) begin
            for (int f = timer_pkg::F_PRESC; f <= timer_pkg::F_MASK; f++) begin
                if (f != timer_pkg::F_COUNT && f != timer_pkg::F_FLAGS) begin
                    bus_read(c, f, data);
                    check($sformatf("rdata ch%0d field%0d", c, f), data, cfg_pattern(c, f));
                end
            end
            bus_write(c, timer_pkg::F_MASK, 16'h0);   // irq off for the pwm runs
        end
        bus_write(3, timer_pkg::F_TOP, 16'hffff);   // no channel 3
        bus_read(3, timer_pkg::F_TOP, data);
        check("rdata unused channel", data, 0);

        // table of pwm settings
        for (int r = 0; r < NUM_ROWS; r++) begin
            row = row_at(r);
            ch  = row.ch;
            if (!row.relatch) begin
                bus_write(ch, timer_pkg::F_CTRL, 16'h0);   // stop, so go rises again
                bus_write(ch, timer_pkg::F_PRESC, 16'(row.presc));
            end
            bus_write(ch, timer_pkg::F_TOP, row.top);
            bus_write(ch, timer_pkg::F_CMP, row.cmp);
            bus_write(ch, timer_pkg::F_CTRL, row.relatch ? 16'h3 : 16'h1);
            wait_pwm(ch, 1'b0);
            wait_pwm(ch, 1'b1);
            measure_period(ch, period, high);   // may span the switch, not checked
            measure_period(ch, period, high);
            check($sformatf("row %0d pwm[%0d] period", r, ch), period, row.period);
            check($sformatf("row %0d pwm[%0d] high", r, ch), high, row.high);
        end

        // top flag of channel 0 into irq
        bus_write(0, timer_pkg::F_MASK, 16'h1);
        wait_irq(1'b1);
        bus_read(0, timer_pkg::F_FLAGS, data);
        check("flags ch0 top bit", data[timer_pkg::FLAG_TOP], 1);
        wait_pwm(0, 1'b0);
        wait_pwm(0, 1'b1);   // counter just wrapped, next top match is a period away
        bus_write(0, timer_pkg::F_FLAGS, data);    // write one to clear
        bus_read(0, timer_pkg::F_FLAGS, data);
        check("flags ch0 top bit after clear", data[timer_pkg::FLAG_TOP], 0);
        bus_write(0, timer_pkg::F_MASK, 16'h0);
        bus_write(0, timer_pkg::F_FLAGS, 16'h3);
        wait_irq(1'b0);

        // stop both channels, counters must hold
        for (int c = 0; c < NUM_CH; c++) begin
            bus_write(c, timer_pkg::F_CTRL, 16'h0);
            repeat (2) @(negedge clk);   // run latch drops one edge after go
            check($sformatf("pwm[%0d] after stop", c), pwm[c], 0);
            bus_read(c, timer_pkg::F_COUNT, count_a);
            repeat (5) @(negedge clk);
            bus_read(c, timer_pkg::F_COUNT, data);
            check($sformatf("count ch%0d held", c), data, count_a);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+bench
common/timer_pkg.sv
timer/timer.sv
timer/timer_regs.sv
verilog/timer_irq.sv
verilog/pwm_timer_top.sv
bench/tb_pwm_timer.sv

// ==== Bender.yml ====
package:
  name: pwm_timer

sources:
  - common/timer_pkg.sv
  - timer/timer.sv
  - timer/timer_regs.sv
  - verilog/timer_irq.sv
  - verilog/pwm_timer_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_pwm_timer.sv
